// File: Bender.yml
package:
  name: soc_fabric

sources:
  - files:
      - common/soc_pkg.sv
      - verilog/ram.sv
      - verilog/bus_decoder.sv
      - bridge/bridge_fsm.sv
      - bridge/periph_block.sv
      - timer/timer.sv
      - verilog/soc_fabric.sv
  - target: test
    files:
      - verification/tb_soc_fabric_properties.sv
      - verification/tb_soc_fabric.sv

// File: bridge/bridge_fsm.sv
module bridge_fsm
	import soc_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_rst_n,
	input  logic      i_request,
	input  logic      i_rw,
	input  far_addr_t i_address,
	input  data_t     i_wdata,
	input  data_t     i_far_rdata,
	input  logic      i_far_ready,
	output data_t     o_rdata,
	output logic      o_ready,
	output logic      o_far_request,
	output logic      o_far_rw,
	output far_addr_t o_far_address,
	output data_t     o_far_wdata
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		DONE
	} state_e;

	state_e state;

	//============================================================
	// Control

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (i_request) begin
						state <= ISSUE;
					end
				end
				ISSUE: state <= WAIT;
				WAIT: begin
					if (i_far_ready) begin
						state <= DONE;
					end
				end
				// Near request is ignored while ready is high
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Single-cycle pulses on both sides
	assign o_far_request = state == ISSUE;
	assign o_ready = state == DONE;

	//============================================================
	// Payload

	// Far side sees the latched access until the next one
	always_ff @(posedge i_clock) begin
		if (state == IDLE && i_request) begin
			o_far_rw <= i_rw;
			o_far_address <= i_address;
			o_far_wdata <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == WAIT && i_far_ready) begin
			o_rdata <= i_far_rdata;
		end
	end

endmodule

// File: bridge/periph_block.sv
module periph_block
	import soc_pkg::*;
(
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_far_request,
	input  logic                 i_far_rw,
	input  far_addr_t            i_far_address,
	input  data_t                i_far_wdata,
	input  data_t                i_timer_rdata,
	input  logic                 i_timer_ready,
	output data_t                o_far_rdata,
	output logic                 o_far_ready,
	output logic [LED_WIDTH-1:0] o_leds,
	output logic                 o_timer_request,
	output logic                 o_timer_rw,
	output timer_reg_e           o_timer_reg,
	output data_t                o_timer_wdata
);

	logic [3:0] device;
	logic led_select;
	logic timer_select;
	logic local_ready;

	assign device = device_of(i_far_address);
	assign led_select = device == DEV_LED;
	assign timer_select = device == DEV_TIMER;

	// Timer is a separate block
	assign o_timer_request = i_far_request && timer_select;
	assign o_timer_rw = i_far_rw;
	assign o_timer_reg = timer_reg_of(i_far_address);
	assign o_timer_wdata = i_far_wdata;

	// LED register
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_leds <= '0;
		end else if (i_far_request && led_select && i_far_rw) begin
			o_leds <= i_far_wdata[LED_WIDTH-1:0];
		end
	end

	// LED and unknown devices answer one cycle after the request
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			local_ready <= 1'b0;
		end else begin
			local_ready <= i_far_request && !timer_select;
		end
	end

	assign o_far_ready = timer_select ? i_timer_ready : local_ready;

	assign o_far_rdata =
		led_select   ? data_t'(o_leds) :
		timer_select ? i_timer_rdata   :
		'0;

endmodule

// File: common/soc_pkg.sv
package soc_pkg;

	//============================================================
	// Near bus

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Near address without its region nibble
	typedef logic [27:0] far_addr_t;

	// Region codes in near address bits 31..28
	localparam logic [3:0] REGION_RAM = 4'h1;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	function automatic logic [3:0] region_of(input addr_t address);
		return address[31:28];
	endfunction

	//============================================================
	// Far bus behind the bridge

	// Device codes in far address bits 27..24
	localparam logic [3:0] DEV_LED = 4'h0;
	localparam logic [3:0] DEV_TIMER = 4'h5;

	function automatic logic [3:0] device_of(input far_addr_t address);
		return address[27:24];
	endfunction

	localparam int LED_WIDTH = 10;

	// Timer word offsets in far address bits 4..2
	typedef enum logic [2:0] {
		MTIME_LO = 3'd0,
		MTIME_HI = 3'd1,
		MTIMECMP_LO = 3'd2,
		MTIMECMP_HI = 3'd3
	} timer_reg_e;

	// Offsets 4..7 are not enum members and read back as zero
	function automatic timer_reg_e timer_reg_of(input far_addr_t address);
		return timer_reg_e'(address[4:2]);
	endfunction

endpackage

// File: flist.f
common/soc_pkg.sv
verilog/ram.sv
verilog/bus_decoder.sv
bridge/bridge_fsm.sv
bridge/periph_block.sv
timer/timer.sv
verilog/soc_fabric.sv
verification/tb_soc_fabric_properties.sv
verification/tb_soc_fabric.sv

// File: timer/timer.sv
module timer
	import soc_pkg::*;
#(
	parameter int TIMER_PRESCALE = 100
) (
	input  logic       i_clock,
	input  logic       i_rst_n,
	input  logic       i_request,
	input  logic       i_rw,
	input  timer_reg_e i_reg,
	input  data_t      i_wdata,
	output data_t      o_rdata,
	output logic       o_ready,
	output logic       o_irq
);

	localparam int PRESCALE_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;
	localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(TIMER_PRESCALE - 1);

	logic [PRESCALE_W-1:0] prescale_count;
	logic tick;
	logic [63:0] mtime;
	logic [63:0] mtimecmp;
	logic write_access;

	assign tick = prescale_count == PRESCALE_LAST;
	assign write_access = i_request && i_rw;

	//============================================================
	// Counter

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			prescale_count <= '0;
		end else if (tick) begin
			prescale_count <= '0;
		end else begin
			prescale_count <= prescale_count + 1'b1;
		end
	end

	// Bus write wins over a tick in the same cycle
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mtime <= '0;
		end else if (write_access && i_reg == MTIME_LO) begin
			mtime[31:0] <= i_wdata;
		end else if (write_access && i_reg == MTIME_HI) begin
			mtime[63:32] <= i_wdata;
		end else if (tick) begin
			mtime <= mtime + 64'd1;
		end
	end

	// All ones keeps the interrupt quiet out of reset
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mtimecmp <= '1;
		end else if (write_access && i_reg == MTIMECMP_LO) begin
			mtimecmp[31:0] <= i_wdata;
		end else if (write_access && i_reg == MTIMECMP_HI) begin
			mtimecmp[63:32] <= i_wdata;
		end
	end

	assign o_irq = mtime >= mtimecmp;

	//============================================================
	// Register access

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= i_request;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_request && !i_rw) begin
			case (i_reg)
				MTIME_LO: o_rdata <= mtime[31:0];
				MTIME_HI: o_rdata <= mtime[63:32];
				MTIMECMP_LO: o_rdata <= mtimecmp[31:0];
				MTIMECMP_HI: o_rdata <= mtimecmp[63:32];
				default: o_rdata <= '0;
			endcase
		end
	end

endmodule

// File: verification/tb_soc_fabric.sv
module tb_soc_fabric
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCK_HZ = 1000;
	localparam int TIMER_HZ = 250;
	localparam int RAM_WORDS = 512;
	localparam int TIMER_PRESCALE = CLOCK_HZ / TIMER_HZ;
	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int BUS_TIMEOUT = 20;
	localparam int COUNT_GAP = 6;
	localparam int IRQ_WAIT_CYCLES = 400;
	// RAM 66, LED 16, timer count 10, interrupt 5, faults 3
	localparam int PLANNED_ACCESSES = 100;
	localparam longint WATCHDOG_NS = (PLANNED_ACCESSES * 10 + IRQ_WAIT_CYCLES) * CLOCK_PERIOD;
	localparam addr_t LED_ADDRESS = {REGION_BRIDGE, DEV_LED, 24'h0};

	logic clock;
	logic rst_n;
	logic bus_request;
	logic bus_rw;
	addr_t bus_address;
	data_t bus_wdata;
	data_t bus_rdata;
	logic bus_ready;
	logic [LED_WIDTH-1:0] leds;
	logic timer_irq;
	logic bus_fault;
	addr_t fault_address;

	int checks = 0;
	int errors = 0;
	logic [31:0] lfsr_state = 32'h771a_6bcd;

	soc_fabric #(
		.CLOCK_HZ (CLOCK_HZ),
		.TIMER_HZ (TIMER_HZ),
		.RAM_WORDS(RAM_WORDS)
	) dut_i (
		.i_clock        (clock),
		.i_rst_n        (rst_n),
		.i_bus_request  (bus_request),
		.i_bus_rw       (bus_rw),
		.i_bus_address  (bus_address),
		.i_bus_wdata    (bus_wdata),
		.o_bus_rdata    (bus_rdata),
		.o_bus_ready    (bus_ready),
		.o_leds         (leds),
		.o_timer_irq    (timer_irq),
		.o_bus_fault    (bus_fault),
		.o_fault_address(fault_address)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	//============================================================
	// Helpers

	// Taps 32, 22, 2 and 1 with one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic addr_t ram_address(input logic [25:0] word);
		return {REGION_RAM, word, 2'b00};
	endfunction

	function automatic addr_t timer_address(input timer_reg_e offset);
		return {REGION_BRIDGE, DEV_TIMER, 19'h0, offset, 2'b00};
	endfunction

	task automatic expect_equal(input string what, input data_t got, input data_t expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic expect_true(input string what, input logic condition);
		checks++;
		assert (condition === 1'b1) else begin
			errors++;
			$display("Mismatch at %0d ns: %s does not hold", $time, what);
		end
	endtask

	// Request raised on a falling edge and ready looked for on later ones
	task automatic drive_access(input logic rw, input addr_t address, input data_t wdata,
			output data_t rdata);
		int waited;
		logic answered;
		waited = 0;
		answered = 1'b0;
		rdata = '0;
		@(negedge clock);
		bus_request = 1'b1;
		bus_rw = rw;
		bus_address = address;
		bus_wdata = wdata;
		while (!answered && waited < BUS_TIMEOUT) begin
			@(negedge clock);
			waited++;
			if (bus_ready) begin
				answered = 1'b1;
				rdata = bus_rdata;
			end
		end
		bus_request = 1'b0;
		checks++;
		assert (answered) else begin
			errors++;
			$display("Bus access to %h got no ready within %0d cycles", address, BUS_TIMEOUT);
		end
	endtask

	task automatic bus_write(input addr_t address, input data_t wdata);
		data_t unused;
		drive_access(1'b1, address, wdata, unused);
	endtask

	task automatic bus_read(input addr_t address, output data_t rdata);
		drive_access(1'b0, address, '0, rdata);
	endtask

	//============================================================
	// Directed tests

	task automatic reset_state();
		expect_true("bus ready low after reset", !bus_ready);
		expect_equal("LED register after reset", data_t'(leds), '0);
		expect_true("timer interrupt low after reset", !timer_irq);
		expect_true("fault flag low after reset", !bus_fault);
	endtask

	task automatic ram_patterns();
		logic [25:0] words [32];
		data_t model [RAM_WORDS];
		data_t value;
		data_t rdata;
		logic [25:0] alias_word;
		for (int i = 0; i < 32; i++) begin
			words[i] = random_bits(26);
			value = random_bits(32);
			bus_write(ram_address(words[i]), value);
			model[words[i] % RAM_WORDS] = value;
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(ram_address(words[i]), rdata);
			expect_equal("RAM word", rdata, model[words[i] % RAM_WORDS]);
		end
		// One full RAM depth higher lands on the same word
		alias_word = words[0] + 26'(RAM_WORDS);
		value = random_bits(32);
		bus_write(ram_address(alias_word), value);
		model[alias_word % RAM_WORDS] = value;
		bus_read(ram_address(words[0]), rdata);
		expect_equal("RAM alias word", rdata, model[words[0] % RAM_WORDS]);
	endtask

	task automatic led_register();
		data_t value;
		data_t rdata;
		repeat (8) begin
			value = random_bits(32);
			bus_write(LED_ADDRESS, value);
			expect_equal("LED outputs", data_t'(leds), data_t'(value[LED_WIDTH-1:0]));
			bus_read(LED_ADDRESS, rdata);
			expect_equal("LED readback", rdata, data_t'(value[LED_WIDTH-1:0]));
		end
	endtask

	task automatic timer_counting();
		data_t first;
		data_t second;
		data_t rdata;
		time first_time;
		longint elapsed;
		bus_write(timer_address(MTIME_HI), '0);
		bus_write(timer_address(MTIME_LO), '0);
		bus_read(timer_address(MTIME_LO), first);
		first_time = $time;
		repeat (COUNT_GAP) begin
			bus_read(timer_address(MTIMECMP_LO), rdata);
			expect_equal("MTIMECMP_LO after reset", rdata, 32'hffff_ffff);
		end
		bus_read(timer_address(MTIME_LO), second);
		elapsed = ($time - first_time) / CLOCK_PERIOD;
		expect_true("mtime not going backwards", second >= first);
		expect_true("mtime within prescaled clocks",
			second - first <= elapsed / TIMER_PRESCALE + 1);
	endtask

	task automatic timer_interrupt();
		data_t now;
		data_t compare;
		data_t rdata;
		int waited;
		bus_read(timer_address(MTIME_LO), now);
		compare = now + 32'd20;
		bus_write(timer_address(MTIMECMP_HI), '0);
		bus_write(timer_address(MTIMECMP_LO), compare);
		expect_true("interrupt low right after compare write", !timer_irq);
		waited = 0;
		while (!timer_irq && waited < IRQ_WAIT_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		checks++;
		assert (timer_irq) else begin
			errors++;
			$display("Timer interrupt did not rise within %0d cycles", IRQ_WAIT_CYCLES);
		end
		bus_read(timer_address(MTIME_LO), rdata);
		expect_true("mtime at or past compare", rdata >= compare);
		bus_write(timer_address(MTIMECMP_HI), '1);
		expect_true("interrupt low after compare raised", !timer_irq);
	endtask

	task automatic fault_capture();
		data_t rdata;
		bus_read(32'h7000_0100, rdata);
		expect_equal("unmapped read data", rdata, '0);
		expect_true("fault flag after region 7 access", bus_fault);
		expect_equal("fault address", fault_address, 32'h7000_0100);
		bus_write(32'h9000_0040, random_bits(32));
		expect_true("fault flag still set", bus_fault);
		expect_equal("fault address", fault_address, 32'h9000_0040);
		// Unknown far device answers inside the bridge, not as a fault
		bus_read({REGION_BRIDGE, 4'h3, 24'h000010}, rdata);
		expect_equal("unknown far device data", rdata, '0);
		expect_true("fault flag kept after bridge access", bus_fault);
		expect_equal("fault address after bridge access", fault_address, 32'h9000_0040);
	endtask

	//============================================================
	// Sequence and watchdog

	initial begin
		rst_n = 1'b0;
		bus_request = 1'b0;
		bus_rw = 1'b0;
		bus_address = '0;
		bus_wdata = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		reset_state();
		ram_patterns();
		led_register();
		timer_counting();
		timer_interrupt();
		fault_capture();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: verification/tb_soc_fabric_properties.sv
module tb_soc_fabric_properties (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_ram_request,
	input logic i_bridge_request,
	input logic i_bus_ready,
	input logic i_timer_request,
	input logic i_timer_rw,
	input logic i_timer_irq,
	input logic i_bus_fault
);

	timeunit 1ns;
	timeprecision 1ps;

	logic timer_written;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			timer_written <= 1'b0;
		end else if (i_timer_request && i_timer_rw) begin
			timer_written <= 1'b1;
		end
	end

	//============================================================
	// Handshake

	ready_single_cycle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_bus_ready |=> !i_bus_ready)
		else $error("Bus ready high for two cycles in a row");

	ram_latency: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_ram_request) |=> i_bus_ready)
		else $error("RAM request not answered after one cycle");

	bridge_latency: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_bridge_request) |=> !i_bus_ready ##1 !i_bus_ready ##1 i_bus_ready)
		else $error("Bridge request not answered after three cycles");

	// Compare register still all ones
	irq_quiet: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(!i_bus_fault && !timer_written) |-> !i_timer_irq)
		else $error("Timer interrupt raised before the timer was written");

endmodule

bind soc_fabric tb_soc_fabric_properties properties_i (
	.i_clock         (i_clock),
	.i_rst_n         (i_rst_n),
	.i_ram_request   (ram_request),
	.i_bridge_request(bridge_request),
	.i_bus_ready     (o_bus_ready),
	.i_timer_request (timer_request),
	.i_timer_rw      (timer_rw),
	.i_timer_irq     (o_timer_irq),
	.i_bus_fault     (o_bus_fault)
);

// File: verilog/bus_decoder.sv
module bus_decoder
	import soc_pkg::*;
(
	input  logic  i_clock,
	input  logic  i_rst_n,
	input  logic  i_bus_request,
	input  addr_t i_bus_address,
	input  data_t i_ram_rdata,
	input  logic  i_ram_ready,
	input  data_t i_bridge_rdata,
	input  logic  i_bridge_ready,
	output logic  o_ram_request,
	output logic  o_bridge_request,
	output data_t o_bus_rdata,
	output logic  o_bus_ready,
	output logic  o_bus_fault,
	output addr_t o_fault_address
);

	logic [3:0] region;
	logic ram_select;
	logic bridge_select;
	logic unmapped_select;
	logic unmapped_ready;
	logic unmapped_access;

	assign region = region_of(i_bus_address);
	assign ram_select = region == REGION_RAM;
	assign bridge_select = region == REGION_BRIDGE;
	assign unmapped_select = !ram_select && !bridge_select;

	assign o_ram_request = i_bus_request && ram_select;
	assign o_bridge_request = i_bus_request && bridge_select;

	// Unmapped accesses are sampled once, not again while ready is up
	assign unmapped_access = i_bus_request && unmapped_select && !unmapped_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= unmapped_access;
		end
	end

	//============================================================
	// Fault capture

	// Sticky flag and the address of the latest fault
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_fault <= 1'b0;
			o_fault_address <= '0;
		end else if (unmapped_access) begin
			o_bus_fault <= 1'b1;
			o_fault_address <= i_bus_address;
		end
	end

	// Response mux where unmapped regions read as zero
	always_comb begin
		if (ram_select) begin
			o_bus_rdata = i_ram_rdata;
			o_bus_ready = i_ram_ready;
		end else if (bridge_select) begin
			o_bus_rdata = i_bridge_rdata;
			o_bus_ready = i_bridge_ready;
		end else begin
			o_bus_rdata = '0;
			o_bus_ready = unmapped_ready;
		end
	end

endmodule

// File: verilog/ram.sv
module ram
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 512
) (
	input  logic  i_clock,
	input  logic  i_rst_n,
	input  logic  i_request,
	input  logic  i_rw,
	input  addr_t i_address,
	input  data_t i_wdata,
	output data_t o_rdata,
	output logic  o_ready
);

	// RAM_WORDS is a power of two, so higher addresses alias
	localparam int INDEX_W = $clog2(RAM_WORDS);

	data_t mem [RAM_WORDS];
	logic [INDEX_W-1:0] index;
	logic access;

	assign index = i_address[INDEX_W+1:2];
	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
		end
	end

	// Read word stays on o_rdata until the next read
	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_rw) begin
				mem[index] <= i_wdata;
			end else begin
				o_rdata <= mem[index];
			end
		end
	end

endmodule

// File: verilog/soc_fabric.sv
module soc_fabric
	import soc_pkg::*;
#(
	parameter int CLOCK_HZ = 100_000_000,
	parameter int TIMER_HZ = 1_000_000,
	parameter int RAM_WORDS = 512
) (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_bus_request,
	input  logic                 i_bus_rw,
	input  addr_t                i_bus_address,
	input  data_t                i_bus_wdata,
	output data_t                o_bus_rdata,
	output logic                 o_bus_ready,
	output logic [LED_WIDTH-1:0] o_leds,
	output logic                 o_timer_irq,
	output logic                 o_bus_fault,
	output addr_t                o_fault_address
);

	// Clocks per timer tick with a floor of one
	localparam int TIMER_PRESCALE = (CLOCK_HZ / TIMER_HZ < 1) ? 1 : CLOCK_HZ / TIMER_HZ;

	//============================================================
	// Near side

	logic ram_request;
	data_t ram_rdata;
	logic ram_ready;

	logic bridge_request;
	data_t bridge_rdata;
	logic bridge_ready;

	bus_decoder decoder_i (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_bus_request   (i_bus_request),
		.i_bus_address   (i_bus_address),
		.i_ram_rdata     (ram_rdata),
		.i_ram_ready     (ram_ready),
		.i_bridge_rdata  (bridge_rdata),
		.i_bridge_ready  (bridge_ready),
		.o_ram_request   (ram_request),
		.o_bridge_request(bridge_request),
		.o_bus_rdata     (o_bus_rdata),
		.o_bus_ready     (o_bus_ready),
		.o_bus_fault     (o_bus_fault),
		.o_fault_address (o_fault_address)
	);

	ram #(
		.RAM_WORDS(RAM_WORDS)
	) ram_i (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_request(ram_request),
		.i_rw     (i_bus_rw),
		.i_address(i_bus_address),
		.i_wdata  (i_bus_wdata),
		.o_rdata  (ram_rdata),
		.o_ready  (ram_ready)
	);

	//============================================================
	// North bridge and far devices

	logic far_request;
	logic far_rw;
	far_addr_t far_address;
	data_t far_wdata;
	data_t far_rdata;
	logic far_ready;

	bridge_fsm bridge_i (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_request    (bridge_request),
		.i_rw         (i_bus_rw),
		.i_address    (i_bus_address[27:0]),
		.i_wdata      (i_bus_wdata),
		.i_far_rdata  (far_rdata),
		.i_far_ready  (far_ready),
		.o_rdata      (bridge_rdata),
		.o_ready      (bridge_ready),
		.o_far_request(far_request),
		.o_far_rw     (far_rw),
		.o_far_address(far_address),
		.o_far_wdata  (far_wdata)
	);

	logic timer_request;
	logic timer_rw;
	timer_reg_e timer_reg;
	data_t timer_wdata;
	data_t timer_rdata;
	logic timer_ready;

	periph_block periph_i (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_far_request  (far_request),
		.i_far_rw       (far_rw),
		.i_far_address  (far_address),
		.i_far_wdata    (far_wdata),
		.i_timer_rdata  (timer_rdata),
		.i_timer_ready  (timer_ready),
		.o_far_rdata    (far_rdata),
		.o_far_ready    (far_ready),
		.o_leds         (o_leds),
		.o_timer_request(timer_request),
		.o_timer_rw     (timer_rw),
		.o_timer_reg    (timer_reg),
		.o_timer_wdata  (timer_wdata)
	);

	timer #(
		.TIMER_PRESCALE(TIMER_PRESCALE)
	) timer_i (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_request(timer_request),
		.i_rw     (timer_rw),
		.i_reg    (timer_reg),
		.i_wdata  (timer_wdata),
		.o_rdata  (timer_rdata),
		.o_ready  (timer_ready),
		.o_irq    (o_timer_irq)
	);

endmodule
